/* project.f */
+incdir+source
source/cache_pkg.sv
source/block_ram.sv
source/refill_if.sv
source/tlb_unit.sv
source/cache_ctrl.sv
source/mem_bridge.sv
source/vm_cache_top.sv
verif/vm_cache_assertions.sv
verif/vm_cache_tb.sv

/* Makefile */
# Verilator build and run of the translated cache testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass line"
	@echo "  clean  remove the build directory and $(LOG)"

test:
	verilator --binary --timing --assert -f project.f --top-module vm_cache_tb \
		-Mdir obj_dir -o vm_cache_sim
	./obj_dir/vm_cache_sim | tee $(LOG)
	grep -q -x ">>> PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verif/cache_stimulus.txt */
// op addr data expect paddr nreq (hex); op 1 read, 2 write, 3 tlb write, 4 mode
// 5 tlb write during next refill, 6 read expecting mmu fault, 0 end; mode bit0 vmem bit1 inhibit
1 00001000 00000000 A5A51000 00001000 2
1 00001004 00000000 A5A51004 00001004 0
1 00001000 00000000 A5A51000 00001000 0
2 00001004 12345678 00000000 00001004 1
1 00001004 00000000 12345678 00001004 0
2 00002008 CAFE0001 00000000 00002008 1
1 00002008 00000000 CAFE0001 00002008 2
3 00000C00 00020001 00000000 00000000 0
4 00000000 00000001 00000000 00000000 0
1 00040C10 00000000 A5AD0C10 00080C10 2
1 00040C14 00000000 A5AD0C14 00080C14 0
6 00080C10 00000000 00000000 00000000 0
4 00000000 00000000 00000000 00000000 0
5 00001400 00030001 00000000 00000000 0
1 00003010 00000000 A5A53010 00003010 2
4 00000000 00000001 00000000 00000000 0
1 00041420 00000000 A5A91420 000C1420 2
4 00000000 00000002 00000000 00000000 0
2 00001000 DEADBEEF 00000000 00001000 0
4 00000000 00000000 00000000 00000000 0
1 00001000 00000000 A5A51000 00001000 0
0 00000000 00000000 00000000 00000000 0

/* verif/vm_cache_tb.sv */
/*
  Testbench of the translated write-through cache.
  Runs the operations of the stimulus file against the DUT,
  answers the memory bus from a model with random latency
  and checks data, bus traffic, faults and tlb_busy.
*/
`timescale 1ns/1ps

module vm_cache_tb;

  localparam int stim_cols  = 6;
  localparam int stim_rows  = 32;
  localparam int wait_limit = 200;
  localparam cache_pkg::word_t model_key = 32'hA5A5_0000;

  logic                  CPU_CLK;
  logic                  RST;
  cache_pkg::word_t      cpu_addr;
  logic                  cpu_en;
  logic                  cpu_we;
  cache_pkg::word_t      cpu_wdata;
  cache_pkg::word_t      cpu_rdata;
  logic                  cpu_ready;
  logic                  vmem_act;
  logic                  cache_inhibit;
  logic                  tlb_we;
  cache_pkg::word_t      tlb_wdata;
  logic                  tlb_busy;
  logic                  mmu_fault;
  cache_pkg::word_t      mem_addr;
  logic                  mem_we;
  logic                  mem_req;
  cache_pkg::word_t      mem_wdata;
  logic                  mem_ack;
  cache_pkg::word_t      mem_rdata;

  cache_pkg::word_t      stim [stim_rows*stim_cols];
  cache_pkg::word_t      mem_store [cache_pkg::word_t];
  cache_pkg::tlb_entry_t tlb_shadow [int];
  // bus requests seen during the current access
  cache_pkg::word_t      req_addr_q [$];
  logic                  req_we_q [$];
  cache_pkg::word_t      req_data_q [$];
  integer                seed;
  int                    model_delay;
  logic                  model_busy;
  int                    errors;
  int                    checks;
  logic                  hung;
  // tlb write to slip into the next refill
  logic                  tlb_armed;
  cache_pkg::word_t      arm_addr;
  cache_pkg::word_t      arm_data;

  vm_cache_top dut_i (.*);

  bind vm_cache_top vm_cache_assertions assert_i (.*);

  initial CPU_CLK = 1'b0;
  always #5 CPU_CLK = ~CPU_CLK;

  // --------------------------------------------------------------------------
  // memory model
  // --------------------------------------------------------------------------
  // unwritten words read back as address xor key
  function automatic cache_pkg::word_t model_word(input cache_pkg::word_t addr);
    if (mem_store.exists(addr))
      return mem_store[addr];
    return addr ^ model_key;
  endfunction

  always @(posedge CPU_CLK)
  begin
    if (mem_ack)
      mem_ack <= 1'b0;
    else if (mem_req)
    begin
      if (!model_busy)
      begin
        model_busy  = 1'b1;
        model_delay = $unsigned($random(seed)) % 4;
        req_addr_q.push_back(mem_addr);
        req_we_q.push_back(mem_we);
        req_data_q.push_back(mem_wdata);
        $display("%0t mem %s addr %h data %h", $time, mem_we ? "write" : "read",
                 mem_addr, mem_wdata);
      end
      if (model_delay == 0)
      begin
        model_busy = 1'b0;
        mem_ack   <= 1'b1;
        if (mem_we)
          mem_store[mem_addr] = mem_wdata;
        else
          mem_rdata <= model_word(mem_addr);
      end
      else
        model_delay--;
    end
  end

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------
  task automatic check_word(input string name, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // physical tag on the bus against a tlb entry
  task automatic check_tlb(input string name, input cache_pkg::tlb_entry_t exp,
                           input cache_pkg::word_t bus_addr);
    checks++;
    if (bus_addr[31:18] !== exp.ptag)
    begin
      errors++;
      $display("error %0t %s got %h expected %h", $time, name, bus_addr[31:18], exp.ptag);
    end
  endtask

  task automatic check_requests(input cache_pkg::word_t vaddr, input cache_pkg::word_t paddr,
                                input int nreq, input cache_pkg::word_t wdata);
    check_word("request count", 32'(req_addr_q.size()), 32'(nreq));
    // line refill reads the even word then the odd word
    if (nreq == 2 && req_addr_q.size() == 2)
    begin
      check_word("mem_addr", req_addr_q[0], {paddr[31:3], 3'b000});
      check_word("mem_addr", req_addr_q[1], {paddr[31:3], 3'b100});
      check_bit("mem_we", req_we_q[0], 1'b0);
      check_bit("mem_we", req_we_q[1], 1'b0);
    end
    if (nreq == 1 && req_addr_q.size() == 1)
    begin
      check_word("mem_addr", req_addr_q[0], {paddr[31:2], 2'b00});
      check_bit("mem_we", req_we_q[0], 1'b1);
      check_word("mem_wdata", req_data_q[0], wdata);
    end
    if (vmem_act && req_addr_q.size() > 0 && tlb_shadow.exists(int'(vaddr[17:10])))
      check_tlb("mem_addr ptag", tlb_shadow[int'(vaddr[17:10])], req_addr_q[0]);
  endtask

  // --------------------------------------------------------------------------
  // one cpu access with the address one cycle ahead of the result
  // --------------------------------------------------------------------------
  task automatic run_access(input cache_pkg::word_t addr, input logic we,
                            input cache_pkg::word_t wdata, output logic ready_first,
                            output cache_pkg::word_t rdata);
    int n;
    n = 0;
    @(posedge CPU_CLK);
    cpu_en    <= 1'b1;
    cpu_addr  <= addr;
    cpu_we    <= we;
    cpu_wdata <= wdata;
    @(posedge CPU_CLK);
    cpu_en <= 1'b0;
    cpu_we <= 1'b0;
    if (tlb_armed)
    begin
      // refill is under way by now so the tlb write lands inside it
      @(posedge CPU_CLK);
      tlb_we    <= 1'b1;
      cpu_addr  <= arm_addr;
      tlb_wdata <= arm_data;
      @(posedge CPU_CLK);
      tlb_we <= 1'b0;
      @(negedge CPU_CLK);
      check_bit("tlb_busy", tlb_busy, 1'b1);
    end
    @(negedge CPU_CLK);
    ready_first = cpu_ready;
    while (cpu_ready !== 1'b1 && n < wait_limit)
    begin
      @(negedge CPU_CLK);
      n++;
    end
    if (cpu_ready !== 1'b1)
    begin
      hung = 1'b1;
      errors++;
      $display("timeout: cpu_ready never rose for the access to %h", addr);
    end
    rdata = cpu_rdata;
    if (tlb_armed && !hung)
    begin
      // write still parked in the first cycle after the refill and applied at the next edge
      check_bit("tlb_busy", tlb_busy, 1'b1);
      @(negedge CPU_CLK);
      check_bit("tlb_busy", tlb_busy, 1'b0);
      tlb_shadow[int'(arm_addr[17:10])] = {arm_data[29:16], arm_data[13:0]};
      tlb_armed = 1'b0;
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial
  begin
    int               n;
    int               base;
    logic             rdy0;
    cache_pkg::word_t rdata;
    cache_pkg::word_t op;
    cache_pkg::word_t addr;
    cache_pkg::word_t data;
    cache_pkg::word_t expect_v;
    cache_pkg::word_t paddr;
    cache_pkg::word_t nreq;
    seed          = 82376;
    errors        = 0;
    checks        = 0;
    hung          = 1'b0;
    tlb_armed     = 1'b0;
    model_busy    = 1'b0;
    model_delay   = 0;
    RST           = 1'b0;
    cpu_addr      = '0;
    cpu_en        = 1'b0;
    cpu_we        = 1'b0;
    cpu_wdata     = '0;
    vmem_act      = 1'b0;
    cache_inhibit = 1'b0;
    tlb_we        = 1'b0;
    tlb_wdata     = '0;
    mem_ack       = 1'b0;
    mem_rdata     = '0;
    for (int i = 0; i < stim_rows*stim_cols; i++)
      stim[i] = '0;
    $readmemh("verif/cache_stimulus.txt", stim);
    repeat (16) @(posedge CPU_CLK);
    RST <= 1'b1;
    // reset sweep of the arrays
    n = 0;
    @(negedge CPU_CLK);
    while (cpu_ready !== 1'b1 && n < 300)
    begin
      @(negedge CPU_CLK);
      n++;
    end
    if (cpu_ready !== 1'b1)
    begin
      hung = 1'b1;
      errors++;
      $display("timeout: cpu_ready did not rise after reset");
    end
    for (int row = 0; row < stim_rows && !hung; row++)
    begin
      base     = row * stim_cols;
      op       = stim[base];
      addr     = stim[base+1];
      data     = stim[base+2];
      expect_v = stim[base+3];
      paddr    = stim[base+4];
      nreq     = stim[base+5];
      if (op == 0)
        break;
      req_addr_q.delete();
      req_we_q.delete();
      req_data_q.delete();
      case (op)
        1, 2, 6:
        begin
          run_access(addr, op == 2, data, rdy0, rdata);
          if (op == 1)
            check_word("cpu_rdata", rdata, expect_v);
          if (op == 6)
            check_bit("mmu_fault", mmu_fault, 1'b1);
          // ready right after the lookup only when memory is not needed
          check_bit("cpu_ready", rdy0, nreq == 0);
          // give a stray request time to show up
          if (nreq == 0)
            repeat (3) @(negedge CPU_CLK);
          check_requests(addr, paddr, int'(nreq), data);
        end
        3:
        begin
          @(posedge CPU_CLK);
          tlb_we    <= 1'b1;
          cpu_addr  <= addr;
          tlb_wdata <= data;
          @(posedge CPU_CLK);
          tlb_we <= 1'b0;
          @(negedge CPU_CLK);
          check_bit("tlb_busy", tlb_busy, expect_v[0]);
          tlb_shadow[int'(addr[17:10])] = {data[29:16], data[13:0]};
        end
        4:
        begin
          @(posedge CPU_CLK);
          vmem_act      <= data[0];
          cache_inhibit <= data[1];
        end
        5:
        begin
          tlb_armed = 1'b1;
          arm_addr  = addr;
          arm_data  = data;
        end
        default:
        begin
          errors++;
          $display("stimulus row %0d holds an unknown operation %h", row, op);
        end
      endcase
    end
    errors += dut_i.assert_i.fail_count;
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

/* verif/vm_cache_assertions.sv */
/*
  Protocol assertions for the translated cache, bound to the top.
  Memory request hold rules, cpu/tlb write exclusion and the
  no-request-on-fault rule.
*/
`timescale 1ns/1ps

module vm_cache_assertions
(
  input logic             CPU_CLK,
  input logic             RST,
  input logic             mem_req,
  input logic             mem_ack,
  input cache_pkg::word_t mem_addr,
  input logic             cpu_we,
  input logic             tlb_we,
  input logic             mmu_fault
);

  // number of failed assertions
  int fail_count = 0;

  // request held with a stable address until the ack
  a_req_hold: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (mem_req && !mem_ack) |=> (mem_req && $stable(mem_addr)))
  else
  begin
    $error("mem_req dropped or mem_addr moved before mem_ack");
    fail_count++;
  end

  // bus idles in the cycle after the ack
  a_ack_idle: assert property (@(posedge CPU_CLK) disable iff (!RST)
    (mem_req && mem_ack) |=> !mem_req)
  else
  begin
    $error("mem_req still high in the cycle after mem_ack");
    fail_count++;
  end

  a_we_excl: assert property (@(posedge CPU_CLK) disable iff (!RST)
    !(cpu_we && tlb_we))
  else
  begin
    $error("cpu_we and tlb_we high together");
    fail_count++;
  end

  // a faulting access must not reach memory
  a_no_fault_req: assert property (@(posedge CPU_CLK) disable iff (!RST)
    $rose(mem_req) |-> !mmu_fault)
  else
  begin
    $error("mem_req rose while mmu_fault was high");
    fail_count++;
  end

endmodule

/* source/vm_cache_top.sv */
/*
  Translated write-through cache for the soft CPU.
  Joins the TLB, the cache controller and the memory bridge.
*/
`timescale 1ns/1ps
`include "cache_settings.svh"

module vm_cache_top
(
  input  logic             CPU_CLK,
  input  logic             RST,
  // cpu side, address one cycle early with cpu_en
  input  cache_pkg::word_t cpu_addr,
  input  logic             cpu_en,
  input  logic             cpu_we,
  input  cache_pkg::word_t cpu_wdata,
  output cache_pkg::word_t cpu_rdata,
  output logic             cpu_ready,
  input  logic             vmem_act,
  input  logic             cache_inhibit,
  // tlb update, index from cpu_addr
  input  logic             tlb_we,
  input  cache_pkg::word_t tlb_wdata,
  output logic             tlb_busy,
  output logic             mmu_fault,
  // memory bus
  output cache_pkg::word_t mem_addr,
  output logic             mem_we,
  output logic             mem_req,
  output cache_pkg::word_t mem_wdata,
  input  logic             mem_ack,
  input  cache_pkg::word_t mem_rdata
);

  logic [`CACHE_PTAG_W-1:0] ptag;
  logic                     fault;
  logic                     refill_busy;

  refill_if mem_op_i ();

  assign mmu_fault = fault;

  tlb_unit tlb_i (
    .CPU_CLK     (CPU_CLK),
    .RST         (RST),
    .vaddr       (cpu_addr),
    .lookup      (cpu_en),
    .vmem_act    (vmem_act),
    .tlb_we      (tlb_we),
    .tlb_wdata   (tlb_wdata),
    .refill_busy (refill_busy),
    .ptag        (ptag),
    .fault       (fault),
    .tlb_busy    (tlb_busy)
  );

  cache_ctrl ctrl_i (
    .CPU_CLK       (CPU_CLK),
    .RST           (RST),
    .cpu_addr      (cpu_addr),
    .cpu_en        (cpu_en),
    .cpu_we        (cpu_we),
    .cpu_wdata     (cpu_wdata),
    .cache_inhibit (cache_inhibit),
    .cpu_rdata     (cpu_rdata),
    .cpu_ready     (cpu_ready),
    .ptag          (ptag),
    .fault         (fault),
    .refill_busy   (refill_busy),
    .mem           (mem_op_i.ctrl)
  );

  mem_bridge bridge_i (
    .CPU_CLK   (CPU_CLK),
    .RST       (RST),
    .op        (mem_op_i.bus),
    .mem_addr  (mem_addr),
    .mem_we    (mem_we),
    .mem_req   (mem_req),
    .mem_wdata (mem_wdata),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata)
  );

endmodule

/* source/mem_bridge.sv */
/*
  Memory bus bridge. Takes one operation from the controller,
  puts it on the bus as a held request until mem_ack, captures
  the read word and answers with a one cycle done.
*/
`timescale 1ns/1ps

module mem_bridge
(
  input  logic             CPU_CLK,
  input  logic             RST,
  refill_if.bus            op,
  output cache_pkg::word_t mem_addr,
  output logic             mem_we,
  output logic             mem_req,
  output cache_pkg::word_t mem_wdata,
  input  logic             mem_ack,
  input  cache_pkg::word_t mem_rdata
);

  logic             done_q;
  logic             start;
  logic             ack_seen;
  cache_pkg::word_t rdata_q;

  // ---------------------------------------------------------------------------
  // bus sequencing
  // ---------------------------------------------------------------------------
  // no new start in the done cycle, req is still up there
  assign start    = op.req && !mem_req && !done_q;
  assign ack_seen = mem_req && mem_ack;

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      mem_req <= 1'b0;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= ack_seen;
      // drop right after the ack, bus idles at least one cycle
      if (ack_seen)
        mem_req <= 1'b0;
      else if (start)
        mem_req <= 1'b1;
    end
  end

  // operation held on the bus until the ack
  always_ff @(posedge CPU_CLK)
  begin
    if (start)
    begin
      mem_addr  <= op.addr;
      mem_we    <= (op.op == cache_pkg::op_write);
      mem_wdata <= op.wdata;
    end
    // read word taken in the ack cycle
    if (ack_seen)
      rdata_q <= mem_rdata;
  end

  assign op.done  = done_q;
  assign op.rdata = rdata_q;

endmodule

/* source/cache_ctrl.sv */
/*
  Direct mapped write-through cache controller. Holds the tag and
  data arrays, tests the hit against the translated address,
  refills a two word line on a read miss and passes every write
  on to memory. A reset sweep clears both arrays first.
*/
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ctrl
(
  input  logic                     CPU_CLK,
  input  logic                     RST,
  input  cache_pkg::word_t         cpu_addr,
  input  logic                     cpu_en,
  input  logic                     cpu_we,
  input  cache_pkg::word_t         cpu_wdata,
  input  logic                     cache_inhibit,
  output cache_pkg::word_t         cpu_rdata,
  output logic                     cpu_ready,
  input  logic [`CACHE_PTAG_W-1:0] ptag,
  input  logic                     fault,
  output logic                     refill_busy,
  refill_if.ctrl                   mem
);

  localparam int line_w  = $clog2(`CACHE_LINE_WORDS);
  localparam int tag_w   = `CACHE_PTAG_W + `CACHE_TLB_IDX_W;
  localparam int untr_w  = 32 - `CACHE_PTAG_W;

  typedef enum logic [2:0] {
    st_clear,
    st_idle,
    st_fill0,
    st_fill1,
    st_write
  } state_t;

  state_t                 state;
  logic [`CACHE_IDX_W-1:0] clr_cnt;
  // access latched with cpu_en
  cache_pkg::word_t        cyc_addr;
  cache_pkg::word_t        cyc_wdata;
  logic                    cyc_we;
  logic                    acc_v;
  logic                    wr_pend;
  logic                    req_q;
  // array ports
  cache_pkg::ctag_t        tag_q;
  cache_pkg::ctag_t        tag_wdata;
  cache_pkg::word_t        data_q;
  cache_pkg::word_t        data_wdata;
  logic [`CACHE_IDX_W-1:0] rd_idx;
  logic [`CACHE_IDX_W-1:0] wr_idx;
  logic [`CACHE_IDX_W-1:0] cyc_idx;
  logic                    ram_re;
  logic                    tag_we;
  logic                    data_we;
  // lookup results
  cache_pkg::word_t        paddr;
  logic                    hit;
  logic                    bypass;
  logic                    start_fill;
  logic                    start_write;
  logic                    write_hit;
  logic                    fill_done;
  logic [line_w-1:0]       fill_word;

  // ---------------------------------------------------------------------------
  // hit test on the access latched at the last cpu_en
  // ---------------------------------------------------------------------------
  assign cyc_idx     = cyc_addr[2 +: `CACHE_IDX_W];
  assign paddr       = {ptag, cyc_addr[untr_w-1:0]};
  assign hit         = tag_q.valid && (tag_q.tag == paddr[31 -: tag_w]);
  // faulting or inhibited accesses never touch memory
  assign bypass      = fault || cache_inhibit;
  assign start_fill  = (state == st_idle) && acc_v && !cyc_we && !hit && !bypass;
  assign start_write = (state == st_idle) && wr_pend && !bypass;
  assign write_hit   = start_write && hit;
  assign fill_done   = mem.done && ((state == st_fill0) || (state == st_fill1));
  // even word first
  assign fill_word   = line_w'(state == st_fill1);

  assign cpu_ready   = (state == st_idle) &&
                       (!acc_v || bypass || (cyc_we ? !wr_pend : hit));
  assign cpu_rdata   = data_q;
  assign refill_busy = (state == st_fill0) || (state == st_fill1);

  // new access on cpu_en, otherwise keep rereading the stalled one
  // so refill and write words come back through the bypass
  assign ram_re = cpu_en || !cpu_ready;
  assign rd_idx = cpu_en ? cpu_addr[2 +: `CACHE_IDX_W] : cyc_idx;

  // array write select: sweep, refill word, or write hit
  always_comb
  begin
    tag_we     = 1'b0;
    data_we    = 1'b0;
    wr_idx     = cyc_idx;
    tag_wdata  = '0;
    data_wdata = cyc_wdata;
    if (state == st_clear)
    begin
      tag_we     = 1'b1;
      data_we    = 1'b1;
      wr_idx     = clr_cnt;
      data_wdata = '0;
    end
    else if (fill_done)
    begin
      tag_we          = 1'b1;
      data_we         = 1'b1;
      wr_idx          = {cyc_idx[`CACHE_IDX_W-1:line_w], fill_word};
      tag_wdata.valid = 1'b1;
      tag_wdata.tag   = paddr[31 -: tag_w];
      data_wdata      = mem.rdata;
    end
    else if (write_hit)
      data_we = 1'b1;
  end

  block_ram #(
    .payload_t (cache_pkg::ctag_t),
    .addr_w    (`CACHE_IDX_W)
  ) tag_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_idx),
    .re      (ram_re),
    .rdata   (tag_q),
    .waddr   (wr_idx),
    .we      (tag_we),
    .wdata   (tag_wdata)
  );

  block_ram #(
    .payload_t (cache_pkg::word_t),
    .addr_w    (`CACHE_IDX_W)
  ) data_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (rd_idx),
    .re      (ram_re),
    .rdata   (data_q),
    .waddr   (wr_idx),
    .we      (data_we),
    .wdata   (data_wdata)
  );

  // ---------------------------------------------------------------------------
  // control FSM
  // ---------------------------------------------------------------------------
  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      state   <= st_clear;
      clr_cnt <= '0;
      acc_v   <= 1'b0;
      wr_pend <= 1'b0;
      req_q   <= 1'b0;
    end
    else
    begin
      if (cpu_en)
      begin
        acc_v   <= 1'b1;
        wr_pend <= cpu_we;
      end
      else if ((state == st_idle) && bypass)
      begin
        // served without memory, forget it
        acc_v   <= 1'b0;
        wr_pend <= 1'b0;
      end
      case (state)
        st_clear:
        begin
          clr_cnt <= clr_cnt + 1'b1;
          if (&clr_cnt)
            state <= st_idle;
        end
        st_idle:
        begin
          if (start_fill)
          begin
            state <= st_fill0;
            req_q <= 1'b1;
          end
          else if (start_write)
          begin
            state <= st_write;
            req_q <= 1'b1;
          end
        end
        st_fill0:
        begin
          if (mem.done)
          begin
            req_q <= 1'b0;
            state <= st_fill1;
          end
        end
        st_fill1:
        begin
          // one low cycle of req between the two reads
          if (mem.done)
          begin
            req_q <= 1'b0;
            state <= st_idle;
          end
          else if (!req_q)
            req_q <= 1'b1;
        end
        st_write:
        begin
          if (mem.done)
          begin
            req_q   <= 1'b0;
            wr_pend <= 1'b0;
            state   <= st_idle;
          end
        end
        default:
          state <= st_idle;
      endcase
    end
  end

  // payload of the access, no reset
  always_ff @(posedge CPU_CLK)
  begin
    if (cpu_en)
    begin
      cyc_addr  <= cpu_addr;
      cyc_we    <= cpu_we;
      cyc_wdata <= cpu_wdata;
    end
  end

  // request towards the bridge, stable while req is high
  assign mem.req   = req_q;
  assign mem.op    = (state == st_write) ? cache_pkg::op_write : cache_pkg::op_read;
  assign mem.addr  = (state == st_write) ? {paddr[31:2], 2'b00} :
                     {paddr[31:2+line_w], fill_word, 2'b00};
  assign mem.wdata = cyc_wdata;

endmodule

/* source/tlb_unit.sv */
/*
  Translation table. Looked up together with the cache arrays,
  gives the physical tag and the mmu fault for the current access.
  TLB writes that arrive while a refill runs are parked in a holding
  register and committed when the refill is over.
*/
`timescale 1ns/1ps
`include "cache_settings.svh"

module tlb_unit
(
  input  logic                     CPU_CLK,
  input  logic                     RST,
  input  cache_pkg::word_t         vaddr,
  input  logic                     lookup,
  input  logic                     vmem_act,
  input  logic                     tlb_we,
  input  cache_pkg::word_t         tlb_wdata,
  input  logic                     refill_busy,
  output logic [`CACHE_PTAG_W-1:0] ptag,
  output logic                     fault,
  output logic                     tlb_busy
);

  localparam int idx_lsb  = 2 + `CACHE_IDX_W;
  localparam int vtag_lsb = idx_lsb + `CACHE_TLB_IDX_W;

  cache_pkg::tlb_entry_t       entry_q;
  cache_pkg::tlb_entry_t       new_entry;
  cache_pkg::tlb_entry_t       hold_entry;
  cache_pkg::tlb_entry_t       ram_wdata;
  logic [`CACHE_TLB_IDX_W-1:0] hold_idx;
  logic [`CACHE_TLB_IDX_W-1:0] ram_waddr;
  logic                        ram_we;
  logic                        capture;
  logic                        hold_pend;
  logic                        vmem_q;
  logic [`CACHE_VTAG_W-1:0]    vtag_q;

  // tlb_wdata layout: ptag in 29:16, vtag in 13:0
  assign new_entry.ptag = tlb_wdata[16 +: `CACHE_PTAG_W];
  assign new_entry.vtag = tlb_wdata[0 +: `CACHE_VTAG_W];

  // ---------------------------------------------------------------------------
  // write path
  // ---------------------------------------------------------------------------
  // park the write during a refill, or behind one already parked
  assign capture   = tlb_we && (refill_busy || hold_pend);
  // parked write goes out first once the refill has ended
  assign ram_we    = !refill_busy && (hold_pend || tlb_we);
  assign ram_waddr = hold_pend ? hold_idx : vaddr[idx_lsb +: `CACHE_TLB_IDX_W];
  assign ram_wdata = hold_pend ? hold_entry : new_entry;

  block_ram #(
    .payload_t (cache_pkg::tlb_entry_t),
    .addr_w    (`CACHE_TLB_IDX_W)
  ) tlb_ram_i (
    .CPU_CLK (CPU_CLK),
    .raddr   (vaddr[idx_lsb +: `CACHE_TLB_IDX_W]),
    .re      (lookup),
    .rdata   (entry_q),
    .waddr   (ram_waddr),
    .we      (ram_we),
    .wdata   (ram_wdata)
  );

  always_ff @(posedge CPU_CLK)
  begin
    if (!RST)
    begin
      vmem_q    <= 1'b0;
      hold_pend <= 1'b0;
    end
    else
    begin
      // mode is taken with the access, like the address
      if (lookup)
        vmem_q <= vmem_act;
      if (capture)
        hold_pend <= 1'b1;
      else if (!refill_busy)
        hold_pend <= 1'b0;
    end
  end

  always_ff @(posedge CPU_CLK)
  begin
    if (lookup)
      vtag_q <= vaddr[vtag_lsb +: `CACHE_VTAG_W];
    if (capture)
    begin
      hold_idx   <= vaddr[idx_lsb +: `CACHE_TLB_IDX_W];
      hold_entry <= new_entry;
    end
  end

  // ---------------------------------------------------------------------------
  // translation
  // ---------------------------------------------------------------------------
  // untranslated mode passes the virtual tag straight through
  assign ptag     = vmem_q ? entry_q.ptag : vtag_q;
  assign fault    = vmem_q && (entry_q.vtag != vtag_q);
  assign tlb_busy = hold_pend;

endmodule

/* source/refill_if.sv */
/*
  One memory operation between the cache controller and the
  memory bridge. req is a level held until done pulses.
*/
`timescale 1ns/1ps

interface refill_if;

  // request side, from the controller
  logic               req;
  cache_pkg::mem_op_t op;
  cache_pkg::word_t   addr;
  cache_pkg::word_t   wdata;
  // answer side, from the bridge
  // rdata valid only while done is high
  logic               done;
  cache_pkg::word_t   rdata;

  modport ctrl (output req, op, addr, wdata, input done, rdata);
  modport bus (input req, op, addr, wdata, output done, rdata);

endinterface

/* source/block_ram.sv */
/*
  Simple dual port block RAM, one read and one write port.
  Read data is registered; a write to the address being read
  shows up on the same read (write first).
*/
`timescale 1ns/1ps

module block_ram
#(
  parameter type payload_t = cache_pkg::word_t,
  parameter int  addr_w    = 8
)
(
  input  logic              CPU_CLK,
  input  logic [addr_w-1:0] raddr,
  input  logic              re,
  output payload_t          rdata,
  input  logic [addr_w-1:0] waddr,
  input  logic              we,
  input  payload_t          wdata
);

  payload_t mem [2**addr_w];

  always_ff @(posedge CPU_CLK)
  begin
    if (we)
      mem[waddr] <= wdata;
    // read port only moves when enabled
    if (re)
    begin
      // bypass so a fresh refill word hits on the next lookup
      if (we && (waddr == raddr))
        rdata <= wdata;
      else
        rdata <= mem[raddr];
    end
  end

endmodule

/* source/cache_pkg.sv */
/*
  Shared types of the translated cache: tlb entry, cache tag,
  memory operation code and the data word.
*/
`include "cache_settings.svh"

package cache_pkg;

  // one cpu or memory data word
  typedef logic [31:0] word_t;

  // --------------------------------------------------------------------------
  // translation table entry
  // --------------------------------------------------------------------------
  // ptag replaces address bits 31:18 in translated mode
  // vtag must match the access or the mmu faults
  typedef struct packed {
    logic [`CACHE_PTAG_W-1:0] ptag;
    logic [`CACHE_VTAG_W-1:0] vtag;
  } tlb_entry_t;

  // --------------------------------------------------------------------------
  // cache tag, one per word
  // --------------------------------------------------------------------------
  // tag holds physical address bits 31:10
  typedef struct packed {
    logic                                       valid;
    logic [`CACHE_PTAG_W+`CACHE_TLB_IDX_W-1:0] tag;
  } ctag_t;

  // kind of operation handed to the memory bridge
  typedef enum logic {
    op_read,
    op_write
  } mem_op_t;

endpackage

/* source/cache_settings.svh */
/*
  Geometry of the translated write-through cache.
  Address split: vtag 31:18, tlb index 17:10, word index 9:2.
*/
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// virtual tag, top bits of the cpu address
`define CACHE_VTAG_W 14
// physical tag as stored in the tlb
`define CACHE_PTAG_W 14
// cache word index, one tag per word
`define CACHE_IDX_W 8
// tlb entries, indexed right above the word index
`define CACHE_TLB_IDX_W 8
// words per refill line
`define CACHE_LINE_WORDS 2

`endif
